// File: Bender.yml
package:
  name: backend

sources:
  - include_dirs:
      - source
    files:
      - source/backend_pkg.sv
      - source/alu_stage.sv
      - source/pipe_stage_reg.sv
      - source/lsu_stage.sv
      - source/backend_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - tests/backend_tb.sv

// File: backend.f
+incdir+source
source/backend_pkg.sv
source/alu_stage.sv
source/pipe_stage_reg.sv
source/lsu_stage.sv
source/backend_top.sv
tests/backend_tb.sv

// File: source/alu_stage.sv
`timescale 1ns/1ps

`include "backend_settings.svh"

module alu_stage
    import backend_pkg::*;
(
    input  issue_t  issue,
    output ex_mem_t ex_out
);

    localparam int SHAMT_W = $clog2(`BACKEND_XLEN);

    logic [SHAMT_W-1:0]       shamt;
    logic [`BACKEND_XLEN-1:0] alu_result;
    logic                     is_mem_op;

    // shifts only look at the low bits of src_b
    assign shamt = issue.src_b[SHAMT_W-1:0];

    assign is_mem_op = (issue.lsu_op != LSU_NONE);

    always_comb
    begin
        unique case (issue.alu_op)
            ALU_ADD:
            begin
                alu_result = issue.src_a + issue.src_b;
            end
            ALU_SUB:
            begin
                alu_result = issue.src_a - issue.src_b;
            end
            ALU_AND:
            begin
                alu_result = issue.src_a & issue.src_b;
            end
            ALU_OR:
            begin
                alu_result = issue.src_a | issue.src_b;
            end
            ALU_XOR:
            begin
                alu_result = issue.src_a ^ issue.src_b;
            end
            ALU_SLL:
            begin
                alu_result = issue.src_a << shamt;
            end
            ALU_SRL:
            begin
                alu_result = issue.src_a >> shamt;
            end
            ALU_SLT:
            begin
                // signed compare, result is 0 or 1
                alu_result = {{(`BACKEND_XLEN-1){1'b0}},
                              ($signed(issue.src_a) < $signed(issue.src_b))};
            end
            default:
            begin
                alu_result = '0;
            end
        endcase
    end

    always_comb
    begin
        ex_out.pc      = issue.pc;
        ex_out.rw_addr = issue.rw_addr;
        ex_out.lsu_op  = issue.lsu_op;
        // address generation replaces the alu result for loads and stores
        ex_out.ex_result = is_mem_op ? (issue.src_a + issue.imm) : alu_result;
        ex_out.lsu_data  = is_mem_op ? issue.src_b : '0;
        // stores never write a register
        ex_out.rw_en = issue.rw_en && (issue.lsu_op != LSU_SW);
    end

endmodule

// File: source/backend_pkg.sv
`include "backend_settings.svh"

package backend_pkg;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

    // memory operation select, lb is sign-extended
    typedef enum logic [1:0] {
        LSU_NONE = 2'd0,
        LSU_LW   = 2'd1,
        LSU_LB   = 2'd2,
        LSU_SW   = 2'd3
    } lsu_op_e;

    // instruction entering execute
    // for memory ops src_a + imm is the address and src_b the store data
    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]           pc;
        alu_op_e                            alu_op;
        lsu_op_e                            lsu_op;
        logic [`BACKEND_XLEN-1:0]           src_a;
        logic [`BACKEND_XLEN-1:0]           src_b;
        logic [`BACKEND_XLEN-1:0]           imm;
        logic                               rw_en;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rw_addr;
    } issue_t;

    // execute to memory
    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]           pc;
        logic [`BACKEND_XLEN-1:0]           ex_result;
        logic                               rw_en;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rw_addr;
        lsu_op_e                            lsu_op;
        logic [`BACKEND_XLEN-1:0]           lsu_data;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic [`BACKEND_XLEN-1:0]           pc;
        logic [`BACKEND_XLEN-1:0]           wb_data;
        logic                               rw_en;
        logic [`BACKEND_REG_ADDR_WIDTH-1:0] rw_addr;
        logic [`BACKEND_EXC_WIDTH-1:0]      except_type;
        logic [`BACKEND_XLEN-1:0]           except_pc;
    } mem_wb_t;

endpackage

// File: source/backend_settings.svh
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// datapath width
`define BACKEND_XLEN 32

// register index width
`define BACKEND_REG_ADDR_WIDTH 5

// data memory depth in words
// only the word index bits of an address are used, higher bits wrap
`define BACKEND_DMEM_WORDS 64

// exception cause field
`define BACKEND_EXC_WIDTH 4

// exception codes
`define BACKEND_EXC_NONE 4'd0
`define BACKEND_EXC_MISALIGN 4'd1

`endif

// File: source/backend_top.sv
`timescale 1ns/1ps

module backend_top
    import backend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    flush,
    input  logic    issue_valid,
    output logic    issue_ready,
    input  issue_t  issue,
    output logic    wb_valid,
    input  logic    wb_ready,
    output mem_wb_t wb
);

    ex_mem_t ex_out;
    ex_mem_t ex_mem_q;
    logic    ex_mem_valid;
    logic    mem_wb_ready;
    logic    mem_fire;
    mem_wb_t lsu_out;

    // execute, combinational
    alu_stage u_alu_stage (
        .issue  (issue),
        .ex_out (ex_out)
    );

    pipe_stage_reg #(
        .payload_t (ex_mem_t)
    ) u_ex_mem_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (stall),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (ex_out),
        .out_valid (ex_mem_valid),
        .out_ready (mem_wb_ready),
        .out_data  (ex_mem_q)
    );

    // handshake of the EX/MEM output, also the store strobe
    assign mem_fire = ex_mem_valid && mem_wb_ready;

    lsu_stage u_lsu_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .mem_in   (ex_mem_q),
        .mem_fire (mem_fire),
        .mem_out  (lsu_out)
    );

    pipe_stage_reg #(
        .payload_t (mem_wb_t)
    ) u_mem_wb_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (stall),
        .in_valid  (ex_mem_valid),
        .in_ready  (mem_wb_ready),
        .in_data   (lsu_out),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb)
    );

endmodule

// File: source/lsu_stage.sv
`timescale 1ns/1ps

`include "backend_settings.svh"

module lsu_stage
    import backend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  ex_mem_t mem_in,
    input  logic    mem_fire,
    output mem_wb_t mem_out
);

    localparam int IDX_W = $clog2(`BACKEND_DMEM_WORDS);

    logic [`BACKEND_XLEN-1:0] dmem [`BACKEND_DMEM_WORDS];

    logic [IDX_W-1:0]         word_idx;
    logic [1:0]               byte_sel;
    logic [`BACKEND_XLEN-1:0] rd_word;
    logic [7:0]               rd_byte;
    logic                     is_word_op;
    logic                     misalign;
    logic                     mem_we;

    // word index from the address, upper bits wrap
    assign word_idx = mem_in.ex_result[2 +: IDX_W];
    assign byte_sel = mem_in.ex_result[1:0];

    // combinational read port
    assign rd_word = dmem[word_idx];
    assign rd_byte = rd_word[{byte_sel, 3'b000} +: 8];

    // only word accesses can be misaligned
    assign is_word_op = (mem_in.lsu_op == LSU_LW) || (mem_in.lsu_op == LSU_SW);
    assign misalign   = is_word_op && (byte_sel != 2'b00);

    // store commits with the transfer into MEM/WB
    assign mem_we = mem_fire && !flush && (mem_in.lsu_op == LSU_SW) && !misalign;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `BACKEND_DMEM_WORDS; i++)
            begin
                dmem[i] <= '0;
            end
        end
        else if (mem_we)
        begin
            dmem[word_idx] <= mem_in.lsu_data;
        end
    end

    always_comb
    begin
        mem_out.pc      = mem_in.pc;
        mem_out.rw_addr = mem_in.rw_addr;
        mem_out.rw_en   = mem_in.rw_en && !misalign;

        unique case (mem_in.lsu_op)
            LSU_LW:
            begin
                mem_out.wb_data = misalign ? mem_in.ex_result : rd_word;
            end
            LSU_LB:
            begin
                mem_out.wb_data = {{(`BACKEND_XLEN-8){rd_byte[7]}}, rd_byte};
            end
            default:
            begin
                // alu ops and stores pass the execute result
                mem_out.wb_data = mem_in.ex_result;
            end
        endcase

        if (misalign)
        begin
            mem_out.except_type = `BACKEND_EXC_MISALIGN;
            mem_out.except_pc   = mem_in.pc;
        end
        else
        begin
            mem_out.except_type = `BACKEND_EXC_NONE;
            mem_out.except_pc   = '0;
        end
    end

    // a faulting item leaving for writeback leaves its word untouched
    property p_no_write_on_exception;
        @(posedge clk) disable iff (!rst_n)
        (mem_fire && misalign) |=> (dmem[$past(word_idx)] == $past(rd_word));
    endproperty

    assert property (p_no_write_on_exception)
        else $error("lsu_stage: memory written by a faulting access");

endmodule

// File: source/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     stall,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;
    logic     load;

    // empty, or the held item leaves this cycle
    assign in_ready = !valid_q || (out_ready && !stall);

    assign load = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n || flush)
        begin
            valid_q <= 1'b0;
        end
        else if (in_ready)
        begin
            valid_q <= in_valid;
        end
    end

    // payload register, only written on an accepted item
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            data_q <= in_data;
        end
    end

    // stall hides the item from the next stage but keeps it
    assign out_valid = valid_q && !stall;
    assign out_data  = data_q;

    // offered item must not change until taken
    property p_hold_under_backpressure;
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> $stable(out_data);
    endproperty

    assert property (p_hold_under_backpressure)
        else $error("pipe_stage_reg: out_data changed under back-pressure");

endmodule

// File: tests/backend_stim.txt
# ins alu_op lsu_op src_a src_b imm rw_en rw_addr, all hex; stall n (decimal); flush; drain
# alu_op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt; lsu_op 0 none 1 lw 2 lb 3 sw
drain
ins 0 0 7fffffff 00000001 00000000 1 01
ins 1 0 00000000 00000001 00000000 1 02
ins 2 0 f0f0f0f0 ff00ff00 00000000 1 03
ins 3 0 f0f0f0f0 0f0f0f0f 00000000 1 04
ins 4 0 ffffffff 12345678 00000000 1 05
ins 5 0 00000001 0000003f 00000000 1 06
ins 6 0 80000000 0000001f 00000000 1 07
ins 7 0 80000000 00000001 00000000 1 08
ins 7 0 00000001 80000000 00000000 1 09
ins 0 0 00000000 00000000 00000000 0 00
# store, then word and byte loads from the same word
ins 0 3 00000040 a5c3817f 00000000 1 0a
ins 0 1 00000030 00000000 00000010 1 0b
ins 0 2 00000040 00000000 00000000 1 0c
ins 0 2 00000040 00000000 00000001 1 0d
ins 0 2 00000040 00000000 00000002 1 0e
ins 0 2 00000043 00000000 00000000 1 0f
# misaligned store and load, then the untouched word
ins 0 3 00000080 deadbeef 00000002 1 10
ins 0 1 00000080 00000000 00000001 1 11
ins 0 1 00000080 00000000 00000000 1 12
ins 0 3 00000144 13579bdf 00000000 1 00
ins 0 1 00000044 00000000 00000000 1 13
stall 3
ins 0 0 00000011 00000022 00000000 1 14
stall 5
ins 4 0 0000ffff 00ff00ff 00000000 1 15
ins 1 0 00000100 00000001 00000000 1 16
ins 5 0 00000003 00000004 00000000 1 17
flush
ins 3 0 00000a00 000000b0 00000000 1 18
stall 2
ins 6 0 ffffffff 00000004 00000000 1 19
drain
ins 7 0 fffffffe ffffffff 00000000 1 1f

// File: tests/backend_tb.sv
`timescale 1ns/1ps

`include "backend_settings.svh"

module backend_tb
    import backend_pkg::*;
();

    localparam STIM_PATH = "tests/backend_stim.txt";

    // wb_ready modes
    localparam int RDY_RANDOM = 0;
    localparam int RDY_HIGH   = 1;
    localparam int RDY_LOW    = 2;

    logic    clk;
    logic    rst_n;
    logic    stall;
    logic    flush;
    logic    issue_valid;
    logic    issue_ready;
    issue_t  issue;
    logic    wb_valid;
    logic    wb_ready;
    mem_wb_t wb;

    // reference model state
    logic [`BACKEND_XLEN-1:0] model_mem [`BACKEND_DMEM_WORDS];
    mem_wb_t                  exp_q [$];
    mem_wb_t                  exp_item;

    logic [31:0] rng_state;
    logic [31:0] next_pc;
    logic        measure_next;
    int          ready_mode;
    int          cycle_cnt = 0;
    int          timeout_limit = 1000000;
    int          last_retire = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          retired = 0;
    int          flushed = 0;

    backend_top u_backend_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb          (wb)
    );

    initial clk = 1'b0;

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected writeback for one instruction, in program order
    function automatic mem_wb_t model_result(input issue_t ins);
        mem_wb_t     r;
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0]  lane;
        addr = ins.src_a + ins.imm;
        word = model_mem[(addr >> 2) % `BACKEND_DMEM_WORDS];
        lane = word >> (8 * addr[1:0]);
        r.pc          = ins.pc;
        r.rw_addr     = ins.rw_addr;
        r.rw_en       = ins.rw_en;
        r.except_type = `BACKEND_EXC_NONE;
        r.except_pc   = '0;
        r.wb_data     = addr;
        case (ins.lsu_op)
            LSU_NONE:
            begin
                case (ins.alu_op)
                    ALU_ADD: r.wb_data = ins.src_a + ins.src_b;
                    ALU_SUB: r.wb_data = ins.src_a - ins.src_b;
                    ALU_AND: r.wb_data = ins.src_a & ins.src_b;
                    ALU_OR:  r.wb_data = ins.src_a | ins.src_b;
                    ALU_XOR: r.wb_data = ins.src_a ^ ins.src_b;
                    ALU_SLL: r.wb_data = ins.src_a << ins.src_b[4:0];
                    ALU_SRL: r.wb_data = ins.src_a >> ins.src_b[4:0];
                    ALU_SLT: r.wb_data = ($signed(ins.src_a) < $signed(ins.src_b)) ? 1 : 0;
                    default: r.wb_data = '0;
                endcase
            end
            LSU_LB:
            begin
                r.wb_data = {{24{lane[7]}}, lane};
            end
            default:
            begin
                // word access, faulting address stays in wb_data
                if (addr[1:0] != 2'b00)
                begin
                    r.rw_en       = 1'b0;
                    r.except_type = `BACKEND_EXC_MISALIGN;
                    r.except_pc   = ins.pc;
                end
                else if (ins.lsu_op == LSU_LW)
                begin
                    r.wb_data = word;
                end
                if (ins.lsu_op == LSU_SW)
                begin
                    r.rw_en = 1'b0;
                end
            end
        endcase
        return r;
    endfunction

    task automatic apply_store(input issue_t ins);
        logic [31:0] addr;
        addr = ins.src_a + ins.imm;
        if (addr[1:0] == 2'b00)
        begin
            model_mem[(addr >> 2) % `BACKEND_DMEM_WORDS] = ins.src_b;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] gotv);
        assert (gotv === expv)
        else
        begin
            $display("[FAIL] %s expected %h got %h", name, expv, gotv);
            value_errs++;
        end
    endtask

    task automatic compare_wb(input mem_wb_t expv, input mem_wb_t gotv);
        check_value("wb.pc", expv.pc, gotv.pc);
        check_value("wb.wb_data", expv.wb_data, gotv.wb_data);
        check_value("wb.rw_en", expv.rw_en, gotv.rw_en);
        check_value("wb.rw_addr", expv.rw_addr, gotv.rw_addr);
        check_value("wb.except_type", expv.except_type, gotv.except_type);
        check_value("wb.except_pc", expv.except_pc, gotv.except_pc);
    endtask

    // sampled at the rising edge, inputs move on the falling edge
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst_n)
        begin
            assert (!(stall && wb_valid))
            else
            begin
                $display("wb_valid was high during a stall at cycle %0d", cycle_cnt);
                other_errs++;
            end
            if (wb_valid && wb_ready)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    $display("writeback of pc %h arrived with nothing outstanding", wb.pc);
                    other_errs++;
                end
                if (exp_q.size() > 0)
                begin
                    exp_item = exp_q.pop_front();
                    compare_wb(exp_item, wb);
                    retired++;
                    last_retire = cycle_cnt;
                end
            end
        end
        if (cycle_cnt >= timeout_limit)
        begin
            $display("timeout, the run did not finish within %0d cycles", timeout_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic drive_ready();
        if (ready_mode == RDY_RANDOM)
        begin
            rng_state = next_rand(rng_state);
            wb_ready  = (rng_state[1:0] != 2'b00);
        end
        else
        begin
            wb_ready = (ready_mode == RDY_HIGH);
        end
    endtask

    task automatic advance();
        @(negedge clk);
        drive_ready();
    endtask

    task automatic wait_empty();
        while (exp_q.size() != 0)
        begin
            advance();
        end
    endtask

    task automatic issue_insn(input issue_t ins);
        logic accepted;
        int   acc_cycle;
        accepted  = 1'b0;
        acc_cycle = 0;
        issue       = ins;
        issue_valid = 1'b1;
        while (!accepted)
        begin
            @(posedge clk);
            if (issue_ready)
            begin
                accepted  = 1'b1;
                acc_cycle = cycle_cnt;
            end
            advance();
        end
        issue_valid = 1'b0;
        exp_q.push_back(model_result(ins));
        if (ins.lsu_op == LSU_SW)
        begin
            apply_store(ins);
        end
        // empty pipe, ready high: two edges from accept to wb transfer
        if (measure_next)
        begin
            wait_empty();
            assert (last_retire == acc_cycle + 2)
            else
            begin
                $display("[FAIL] wb latency expected %h got %h", 2, last_retire - acc_cycle);
                value_errs++;
            end
            measure_next = 1'b0;
            ready_mode   = RDY_RANDOM;
            drive_ready();
        end
    endtask

    task automatic hold_stall(input int n);
        stall = 1'b1;
        repeat (n) advance();
        stall = 1'b0;
    endtask

    task automatic flush_pipe();
        ready_mode = RDY_LOW;
        wb_ready   = 1'b0;
        flush      = 1'b1;
        advance();
        flush   = 1'b0;
        flushed = flushed + exp_q.size();
        exp_q.delete();
        ready_mode = RDY_RANDOM;
        drive_ready();
    endtask

    function automatic int count_stim_lines();
        int            fd;
        int            code;
        int            n;
        logic [127:0]  tok;
        logic [2047:0] rest;
        n  = 0;
        fd = $fopen(STIM_PATH, "r");
        if (fd != 0)
        begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1)
            begin
                if (tok == "#")
                    code = $fgets(rest, fd);
                else if (tok == "ins" || tok == "stall" || tok == "flush" || tok == "drain")
                    n++;
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        return n;
    endfunction

    task automatic run_stim(input int fd);
        logic [127:0]  tok;
        logic [2047:0] rest;
        logic [31:0]   f_alu, f_lsu, f_a, f_b, f_imm, f_en, f_rd;
        issue_t        ins;
        int            code;
        int            n;
        code = $fscanf(fd, "%s", tok);
        while (code == 1)
        begin
            if (tok == "#")
            begin
                code = $fgets(rest, fd);
            end
            else if (tok == "ins")
            begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h",
                               f_alu, f_lsu, f_a, f_b, f_imm, f_en, f_rd);
                assert (code == 7)
                else
                begin
                    $display("malformed instruction line in the stim file");
                    other_errs++;
                end
                ins.pc      = next_pc;
                ins.alu_op  = alu_op_e'(f_alu[3:0]);
                ins.lsu_op  = lsu_op_e'(f_lsu[1:0]);
                ins.src_a   = f_a;
                ins.src_b   = f_b;
                ins.imm     = f_imm;
                ins.rw_en   = f_en[0];
                ins.rw_addr = f_rd[4:0];
                next_pc     = next_pc + 4;
                issue_insn(ins);
            end
            else if (tok == "stall")
            begin
                code = $fscanf(fd, "%d", n);
                hold_stall(n);
            end
            else if (tok == "flush")
            begin
                flush_pipe();
            end
            else if (tok == "drain")
            begin
                ready_mode = RDY_HIGH;
                drive_ready();
                wait_empty();
                measure_next = 1'b1;
            end
            else
            begin
                $display("unknown word %0s in the stim file", tok);
                other_errs++;
            end
            code = $fscanf(fd, "%s", tok);
        end
    endtask

    initial
    begin
        int fd;
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        wb_ready     = 1'b0;
        rng_state    = 32'h06ac_d585;
        next_pc      = 32'h0000_1000;
        ready_mode   = RDY_RANDOM;
        measure_next = 1'b0;
        for (int i = 0; i < `BACKEND_DMEM_WORDS; i++)
        begin
            model_mem[i] = '0;
        end
        timeout_limit = 40 * count_stim_lines() + 200;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        assert (issue_ready && !wb_valid)
        else
        begin
            $display("pipe not empty and ready after reset");
            other_errs++;
        end
        advance();

        fd = $fopen(STIM_PATH, "r");
        if (fd == 0)
        begin
            $display("could not open the stim file %0s", STIM_PATH);
            other_errs++;
        end
        else
        begin
            run_stim(fd);
            $fclose(fd);
        end

        // let everything retire, then watch for strays
        ready_mode = RDY_HIGH;
        drive_ready();
        wait_empty();
        repeat (4) advance();

        $display("errors: %0d wrong values, %0d other; %0d retired, %0d flushed",
                 value_errs, other_errs, retired, flushed);
        if (value_errs == 0 && other_errs == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
